// ==== common/miss_pkg.sv ====
// miss unit package with address geometry, data types and request/return encodings
package miss_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // address geometry
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned PaddrWidth  = 32;
  localparam int unsigned LineWidth   = 128;
  localparam int unsigned OffsetWidth = 4;
  localparam int unsigned NumLines    = 16;
  localparam int unsigned IndexWidth  = 4;
  localparam int unsigned TagWidth    = PaddrWidth - IndexWidth - OffsetWidth;
  localparam int unsigned TidWidth    = 4;
  localparam int unsigned WordWidth   = 64;

  typedef logic [PaddrWidth-1:0] paddr_t;
  typedef logic [LineWidth-1:0]  line_t;
  typedef logic [WordWidth-1:0]  word_t;
  typedef logic [TagWidth-1:0]   tag_t;
  typedef logic [IndexWidth-1:0] cl_idx_t;
  typedef logic [TidWidth-1:0]   tid_t;
  // 0 byte, 1 half, 2 word, 3 double, 7 full line
  typedef logic [2:0]            size_t;

  localparam size_t SizeLine = 3'd7;

  ////////////////////////////////////////////////////////////////////////////
  // request and return encodings
  ////////////////////////////////////////////////////////////////////////////

  typedef enum logic {
    REQ_LOAD,
    REQ_STORE
  } req_type_e;

  typedef enum logic [1:0] {
    RTRN_LOAD_ACK,
    RTRN_STORE_ACK,
    RTRN_OTHER
  } rtrn_type_e;

  // clear the low address bits covered by the access size
  function automatic paddr_t paddr_align(paddr_t paddr, size_t size);
    paddr_t aligned;
    aligned = paddr;
    case (size)
      3'd1:     aligned[0]             = 1'b0;
      3'd2:     aligned[1:0]           = 2'b00;
      3'd3:     aligned[2:0]           = 3'b000;
      SizeLine: aligned[OffsetWidth-1:0] = '0;
      default:  ;
    endcase
    return aligned;
  endfunction

endpackage

// ==== miss_unit/miss_arbiter.sv ====
// miss port arbiter, picks the lowest pending port with read masking and request lock
module miss_arbiter #(
  parameter int unsigned  NumPorts     = 3,
  localparam int unsigned PortIdxWidth = $clog2(NumPorts)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [NumPorts-1:0]     miss_req_i,
  input  logic                    mask_reads_i,
  input  logic                    lock_reqs_i,
  output logic [PortIdxWidth-1:0] port_idx_o,
  output logic                    any_req_o
);

  // the last port is the write port, all others read
  localparam logic [NumPorts-1:0] WriteMask = {1'b1, {(NumPorts-1){1'b0}}};

  logic [NumPorts-1:0] req_masked_d;
  logic [NumPorts-1:0] req_masked_q;

  // locked selection reuses the vector seen when the request went out
  always_comb begin : p_mask
    if (lock_reqs_i) begin
      req_masked_d = req_masked_q;
    end else if (mask_reads_i) begin
      req_masked_d = miss_req_i & WriteMask;
    end else begin
      req_masked_d = miss_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      req_masked_q <= '0;
    end else begin
      req_masked_q <= req_masked_d;
    end
  end

  // walk from the top so the lowest set bit wins
  always_comb begin : p_pick
    port_idx_o = '0;
    for (int i = NumPorts - 1; i >= 0; i--) begin
      if (req_masked_d[i]) begin
        port_idx_o = PortIdxWidth'(i);
      end
    end
  end

  assign any_req_o = |req_masked_d;

endmodule

// ==== miss_unit/miss_mshr.sv ====
// read miss status register with replacement way choice and write collision check
module miss_mshr #(
  parameter int unsigned  NumPorts     = 3,
  parameter int unsigned  NumWays      = 4,
  localparam int unsigned PortIdxWidth = $clog2(NumPorts),
  localparam int unsigned WayWidth     = $clog2(NumWays)
) (
  input  logic                              clk_i,
  input  logic                              rst_ni,
  input  logic                              allocate_i,
  input  logic                              lfsr_step_i,
  input  logic                              load_ack_i,
  input  logic [PortIdxWidth-1:0]           port_idx_i,
  input  miss_pkg::paddr_t [NumPorts-1:0]   miss_paddr_i,
  input  miss_pkg::size_t [NumPorts-1:0]    miss_size_i,
  input  miss_pkg::tid_t [NumPorts-1:0]     miss_id_i,
  input  logic [NumPorts-1:0][NumWays-1:0]  miss_vld_bits_i,
  output logic                              mshr_vld_o,
  output miss_pkg::paddr_t                  mshr_paddr_o,
  output miss_pkg::tid_t                    mshr_id_o,
  output logic [PortIdxWidth-1:0]           mshr_port_o,
  output logic [WayWidth-1:0]               mshr_way_o,
  output logic [WayWidth-1:0]               repl_way_o,
  output logic                              all_ways_valid_o,
  output logic                              wr_collision_o
);

  import miss_pkg::*;

  logic [NumWays-1:0]      vld_bits;
  logic [WayWidth-1:0]     inv_way;
  logic [7:0]              lfsr_q;
  logic                    lfsr_fb;
  logic                    mshr_vld_q;
  paddr_t                  mshr_paddr_q;
  tid_t                    mshr_id_q;
  logic [PortIdxWidth-1:0] mshr_port_q;
  logic [WayWidth-1:0]     mshr_way_q;

  ////////////////////////////////////////////////////////////////////////////
  // replacement way
  ////////////////////////////////////////////////////////////////////////////

  assign vld_bits = miss_vld_bits_i[port_idx_i];

  // first invalid way, lowest index wins
  always_comb begin : p_inv_way
    inv_way = '0;
    for (int w = NumWays - 1; w >= 0; w--) begin
      if (!vld_bits[w]) begin
        inv_way = WayWidth'(w);
      end
    end
  end

  assign all_ways_valid_o = &vld_bits;

  // fibonacci lfsr, taps 8 6 5 4
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_lfsr
    if (!rst_ni) begin
      lfsr_q <= 8'h01;
    end else if (lfsr_step_i) begin
      lfsr_q <= {lfsr_q[6:0], lfsr_fb};
    end
  end

  // random eviction only when every way holds a line
  assign repl_way_o = all_ways_valid_o ? lfsr_q[WayWidth-1:0] : inv_way;

  ////////////////////////////////////////////////////////////////////////////
  // miss register
  ////////////////////////////////////////////////////////////////////////////

  // allocation wins over a clearing load ack in the same cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin : p_vld
    if (!rst_ni) begin
      mshr_vld_q <= 1'b0;
    end else if (allocate_i) begin
      mshr_vld_q <= 1'b1;
    end else if (load_ack_i) begin
      mshr_vld_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin : p_payload
    if (allocate_i) begin
      mshr_paddr_q <= paddr_align(miss_paddr_i[port_idx_i], miss_size_i[port_idx_i]);
      mshr_id_q    <= miss_id_i[port_idx_i];
      mshr_port_q  <= port_idx_i;
      mshr_way_q   <= repl_way_o;
    end
  end

  // a store to the line being refilled has to wait for the refill
  assign wr_collision_o = mshr_vld_q &&
      (miss_paddr_i[NumPorts-1][PaddrWidth-1:OffsetWidth] ==
       mshr_paddr_q[PaddrWidth-1:OffsetWidth]);

  assign mshr_vld_o   = mshr_vld_q;
  assign mshr_paddr_o = mshr_paddr_q;
  assign mshr_id_o    = mshr_id_q;
  assign mshr_port_o  = mshr_port_q;
  assign mshr_way_o   = mshr_way_q;

endmodule

// ==== miss_unit/miss_ctrl.sv ====
// miss control FSM with flush walk, cache enable and store tracking
module miss_ctrl #(
  parameter int unsigned  NumPorts     = 3,
  localparam int unsigned PortIdxWidth = $clog2(NumPorts)
) (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic                    enable_i,
  input  logic                    flush_i,
  input  logic                    wbuffer_empty_i,
  input  logic                    any_req_i,
  input  logic [PortIdxWidth-1:0] port_idx_i,
  input  logic                    mshr_vld_i,
  input  logic                    wr_collision_i,
  input  logic                    all_ways_valid_i,
  input  logic                    mem_ack_i,
  input  logic                    load_ack_i,
  input  logic                    store_ack_in_i,
  output logic                    flush_ack_o,
  output logic                    cache_en_o,
  output logic                    mask_reads_o,
  output logic                    lock_reqs_o,
  output logic                    allocate_o,
  output logic                    lfsr_step_o,
  output logic                    mem_req_o,
  output miss_pkg::req_type_e     mem_type_o,
  output logic                    flush_en_o,
  output miss_pkg::cl_idx_t       flush_idx_o,
  output logic                    store_ack_o
);

  import miss_pkg::*;

  typedef enum logic [2:0] {
    IDLE,
    DRAIN,
    FLUSH,
    STORE_WAIT,
    LOAD_WAIT
  } state_e;

  state_e     state_d, state_q;
  cl_idx_t    cnt_d, cnt_q;
  logic       flush_done;
  logic       enable_d, enable_q;
  logic       flush_ack_d, flush_ack_q;
  logic       miss_is_write;
  logic       store_sent;
  // up to 8 stores in flight
  logic [3:0] stores_q;

  ////////////////////////////////////////////////////////////////////////////
  // flush walk and store tracking
  ////////////////////////////////////////////////////////////////////////////

  assign cnt_d       = flush_en_o ? cnt_q + 1'b1 : '0;
  assign flush_done  = (cnt_q == cl_idx_t'(NumLines - 1));
  assign flush_idx_o = cnt_q;
  assign cache_en_o  = enable_q;

  assign miss_is_write = (port_idx_i == PortIdxWidth'(NumPorts - 1));

  assign store_sent  = mem_req_o && mem_ack_i && (mem_type_o == REQ_STORE);
  // acks with nothing outstanding are dropped
  assign store_ack_o = store_ack_in_i && (stores_q != '0);

  ////////////////////////////////////////////////////////////////////////////
  // control FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_fsm
    state_d      = state_q;
    flush_ack_o  = 1'b0;
    flush_ack_d  = flush_ack_q;
    // disabling takes effect at once, enabling goes through a flush
    enable_d     = enable_q & enable_i;
    flush_en_o   = 1'b0;
    mem_req_o    = 1'b0;
    mem_type_o   = REQ_LOAD;
    allocate_o   = 1'b0;
    lfsr_step_o  = 1'b0;
    lock_reqs_o  = 1'b0;
    // a returning refill frees the MSHR in this very cycle
    mask_reads_o = mshr_vld_i & ~load_ack_i;

    case (state_q)
      IDLE: begin
        if (flush_i || (enable_i && !enable_q)) begin
          if (wbuffer_empty_i && !mshr_vld_i) begin
            flush_ack_d = flush_i;
            state_d     = FLUSH;
          end else begin
            state_d = DRAIN;
          end
        end else if (any_req_i) begin
          if (miss_is_write) begin
            // stores pass through unless they hit the pending line
            if (!wr_collision_i) begin
              mem_req_o  = 1'b1;
              mem_type_o = REQ_STORE;
              if (!mem_ack_i) begin
                state_d = STORE_WAIT;
              end
            end
          end else if (!mshr_vld_i || load_ack_i) begin
            mem_req_o   = 1'b1;
            mem_type_o  = REQ_LOAD;
            allocate_o  = mem_ack_i;
            lfsr_step_o = all_ways_valid_i & mem_ack_i;
            if (!mem_ack_i) begin
              state_d = LOAD_WAIT;
            end
          end
        end
      end

      STORE_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_req_o   = 1'b1;
        mem_type_o  = REQ_STORE;
        if (mem_ack_i) begin
          state_d = IDLE;
        end
      end

      LOAD_WAIT: begin
        lock_reqs_o = 1'b1;
        mem_req_o   = 1'b1;
        mem_type_o  = REQ_LOAD;
        if (mem_ack_i) begin
          allocate_o  = 1'b1;
          lfsr_step_o = all_ways_valid_i;
          state_d     = IDLE;
        end
      end

      // only stores go out until the write buffer and MSHR are empty
      DRAIN: begin
        mask_reads_o = 1'b1;
        if (any_req_i && !wr_collision_i) begin
          mem_req_o  = 1'b1;
          mem_type_o = REQ_STORE;
        end
        if (wbuffer_empty_i && !mshr_vld_i) begin
          state_d = IDLE;
        end
      end

      FLUSH: begin
        flush_en_o = 1'b1;
        if (flush_done) begin
          flush_ack_o = flush_ack_q;
          flush_ack_d = 1'b0;
          enable_d    = enable_i;
          state_d     = IDLE;
        end
      end

      default: begin
        state_d = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin : p_regs
    if (!rst_ni) begin
      state_q     <= FLUSH;
      cnt_q       <= '0;
      enable_q    <= 1'b0;
      flush_ack_q <= 1'b0;
      stores_q    <= '0;
    end else begin
      state_q     <= state_d;
      cnt_q       <= cnt_d;
      enable_q    <= enable_d;
      flush_ack_q <= flush_ack_d;
      // a send and an ack together leave the count unchanged
      if (store_sent && !store_ack_o) begin
        stores_q <= stores_q + 1'b1;
      end else if (store_ack_o && !store_sent) begin
        stores_q <= stores_q - 1'b1;
      end
    end
  end

endmodule

// ==== miss_unit/miss_unit.sv ====
// write-through L1 data cache miss unit, memory request mux and cache line write port
module miss_unit #(
  parameter int unsigned  NumPorts     = 3,
  parameter int unsigned  NumWays      = 4,
  localparam int unsigned PortIdxWidth = $clog2(NumPorts),
  localparam int unsigned WayWidth     = $clog2(NumWays)
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,
  input  logic                             enable_i,
  input  logic                             flush_i,
  input  logic                             wbuffer_empty_i,
  output logic                             flush_ack_o,
  output logic                             cache_en_o,
  output logic                             miss_o,
  input  logic [NumPorts-1:0]              miss_req_i,
  input  miss_pkg::paddr_t [NumPorts-1:0]  miss_paddr_i,
  input  miss_pkg::size_t [NumPorts-1:0]   miss_size_i,
  input  miss_pkg::tid_t [NumPorts-1:0]    miss_id_i,
  input  logic [NumPorts-1:0][NumWays-1:0] miss_vld_bits_i,
  input  miss_pkg::word_t [NumPorts-1:0]   miss_wdata_i,
  output logic [NumPorts-1:0]              miss_ack_o,
  output logic [NumPorts-1:0]              miss_rtrn_vld_o,
  output miss_pkg::tid_t                   miss_rtrn_id_o,
  output logic                             mem_req_o,
  output miss_pkg::req_type_e              mem_type_o,
  output miss_pkg::paddr_t                 mem_paddr_o,
  output miss_pkg::size_t                  mem_size_o,
  output miss_pkg::tid_t                   mem_tid_o,
  output logic [WayWidth-1:0]              mem_way_o,
  output miss_pkg::word_t                  mem_wdata_o,
  input  logic                             mem_ack_i,
  input  logic                             mem_rtrn_vld_i,
  input  miss_pkg::rtrn_type_e             mem_rtrn_type_i,
  input  miss_pkg::tid_t                   mem_rtrn_tid_i,
  input  miss_pkg::line_t                  mem_rtrn_data_i,
  output logic                             wr_cl_vld_o,
  output logic [NumWays-1:0]               wr_cl_we_o,
  output miss_pkg::tag_t                   wr_cl_tag_o,
  output miss_pkg::cl_idx_t                wr_cl_idx_o,
  output miss_pkg::line_t                  wr_cl_data_o,
  output logic [NumWays-1:0]               wr_vld_bits_o
);

  import miss_pkg::*;

  logic [PortIdxWidth-1:0] port_idx;
  logic                    any_req;
  logic                    mask_reads;
  logic                    lock_reqs;
  logic                    allocate;
  logic                    lfsr_step;
  logic                    mshr_vld;
  logic                    wr_collision;
  logic                    all_ways_valid;
  logic                    load_ack;
  logic                    store_ack_raw;
  logic                    store_ack;
  logic                    flush_en;
  cl_idx_t                 flush_idx;
  paddr_t                  mshr_paddr;
  tid_t                    mshr_id;
  logic [PortIdxWidth-1:0] mshr_port;
  logic [WayWidth-1:0]     mshr_way;
  logic [WayWidth-1:0]     repl_way;
  logic [NumWays-1:0]      refill_oh;

  miss_arbiter #(
    .NumPorts(NumPorts)
  ) i_arbiter (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .miss_req_i  (miss_req_i),
    .mask_reads_i(mask_reads),
    .lock_reqs_i (lock_reqs),
    .port_idx_o  (port_idx),
    .any_req_o   (any_req)
  );

  miss_mshr #(
    .NumPorts(NumPorts),
    .NumWays (NumWays)
  ) i_mshr (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .allocate_i      (allocate),
    .lfsr_step_i     (lfsr_step),
    .load_ack_i      (load_ack),
    .port_idx_i      (port_idx),
    .miss_paddr_i    (miss_paddr_i),
    .miss_size_i     (miss_size_i),
    .miss_id_i       (miss_id_i),
    .miss_vld_bits_i (miss_vld_bits_i),
    .mshr_vld_o      (mshr_vld),
    .mshr_paddr_o    (mshr_paddr),
    .mshr_id_o       (mshr_id),
    .mshr_port_o     (mshr_port),
    .mshr_way_o      (mshr_way),
    .repl_way_o      (repl_way),
    .all_ways_valid_o(all_ways_valid),
    .wr_collision_o  (wr_collision)
  );

  miss_ctrl #(
    .NumPorts(NumPorts)
  ) i_ctrl (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .enable_i        (enable_i),
    .flush_i         (flush_i),
    .wbuffer_empty_i (wbuffer_empty_i),
    .any_req_i       (any_req),
    .port_idx_i      (port_idx),
    .mshr_vld_i      (mshr_vld),
    .wr_collision_i  (wr_collision),
    .all_ways_valid_i(all_ways_valid),
    .mem_ack_i       (mem_ack_i),
    .load_ack_i      (load_ack),
    .store_ack_in_i  (store_ack_raw),
    .flush_ack_o     (flush_ack_o),
    .cache_en_o      (cache_en_o),
    .mask_reads_o    (mask_reads),
    .lock_reqs_o     (lock_reqs),
    .allocate_o      (allocate),
    .lfsr_step_o     (lfsr_step),
    .mem_req_o       (mem_req_o),
    .mem_type_o      (mem_type_o),
    .flush_en_o      (flush_en),
    .flush_idx_o     (flush_idx),
    .store_ack_o     (store_ack)
  );

  ////////////////////////////////////////////////////////////////////////////
  // memory request and returns
  ////////////////////////////////////////////////////////////////////////////

  assign mem_paddr_o = paddr_align(miss_paddr_i[port_idx], miss_size_i[port_idx]);
  assign mem_size_o  = miss_size_i[port_idx];
  assign mem_tid_o   = miss_id_i[port_idx];
  assign mem_wdata_o = miss_wdata_i[port_idx];
  // stores carry no way
  assign mem_way_o   = (mem_type_o == REQ_LOAD) ? repl_way : '0;
  assign miss_o      = allocate;

  always_comb begin : p_ack
    miss_ack_o           = '0;
    miss_ack_o[port_idx] = mem_req_o & mem_ack_i;
  end

  assign load_ack      = mem_rtrn_vld_i && (mem_rtrn_type_i == RTRN_LOAD_ACK) && mshr_vld;
  assign store_ack_raw = mem_rtrn_vld_i && (mem_rtrn_type_i == RTRN_STORE_ACK);

  always_comb begin : p_rtrn
    miss_rtrn_vld_o = '0;
    if (load_ack) begin
      miss_rtrn_vld_o[mshr_port] = 1'b1;
    end
    if (store_ack) begin
      miss_rtrn_vld_o[NumPorts-1] = 1'b1;
    end
  end

  assign miss_rtrn_id_o = load_ack ? mshr_id : mem_rtrn_tid_i;

  ////////////////////////////////////////////////////////////////////////////
  // cache line write port
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : p_refill_oh
    refill_oh           = '0;
    refill_oh[mshr_way] = 1'b1;
  end

  // flush clears every way of a line, refill sets one way
  assign wr_cl_vld_o   = flush_en | load_ack;
  assign wr_cl_we_o    = flush_en ? '1 : (load_ack ? refill_oh : '0);
  assign wr_vld_bits_o = (!flush_en && load_ack) ? refill_oh : '0;
  assign wr_cl_idx_o   = flush_en ? flush_idx :
                         mshr_paddr[IndexWidth+OffsetWidth-1:OffsetWidth];
  assign wr_cl_tag_o   = mshr_paddr[PaddrWidth-1:IndexWidth+OffsetWidth];
  assign wr_cl_data_o  = mem_rtrn_data_i;

endmodule

// ==== tests/tb_miss_unit.sv ====
// testbench for the miss unit, drives ports and memory and checks the responses
module tb_miss_unit;

  timeunit 1ns;
  timeprecision 100ps;

  import miss_pkg::*;

  localparam int unsigned NumPorts = 3;
  localparam int unsigned NumWays  = 4;
  // six short tests stay well under 500 cycles, four times that as a margin
  localparam int MaxCycles = 2000;

  logic                             clk_i;
  logic                             rst_ni;
  logic                             enable_i;
  logic                             flush_i;
  logic                             wbuffer_empty_i;
  logic                             flush_ack_o;
  logic                             cache_en_o;
  logic                             miss_o;
  logic [NumPorts-1:0]              miss_req_i;
  paddr_t [NumPorts-1:0]            miss_paddr_i;
  size_t [NumPorts-1:0]             miss_size_i;
  tid_t [NumPorts-1:0]              miss_id_i;
  logic [NumPorts-1:0][NumWays-1:0] miss_vld_bits_i;
  word_t [NumPorts-1:0]             miss_wdata_i;
  logic [NumPorts-1:0]              miss_ack_o;
  logic [NumPorts-1:0]              miss_rtrn_vld_o;
  tid_t                             miss_rtrn_id_o;
  logic                             mem_req_o;
  req_type_e                        mem_type_o;
  paddr_t                           mem_paddr_o;
  size_t                            mem_size_o;
  tid_t                             mem_tid_o;
  logic [1:0]                       mem_way_o;
  word_t                            mem_wdata_o;
  logic                             mem_ack_i;
  logic                             mem_rtrn_vld_i;
  rtrn_type_e                       mem_rtrn_type_i;
  tid_t                             mem_rtrn_tid_i;
  line_t                            mem_rtrn_data_i;
  logic                             wr_cl_vld_o;
  logic [NumWays-1:0]               wr_cl_we_o;
  tag_t                             wr_cl_tag_o;
  cl_idx_t                          wr_cl_idx_o;
  line_t                            wr_cl_data_o;
  logic [NumWays-1:0]               wr_vld_bits_o;

  int          errors;
  int          test_errors;
  int          tests_run;
  int          tests_failed;
  int          cycles;
  logic [31:0] rng_q;
  int          ack_wait;

  miss_unit #(
    .NumPorts(NumPorts),
    .NumWays (NumWays)
  ) UUT (
    .*
  );

  ////////////////////////////////////////////////////////////////////////////
  // clock, watchdog and random source
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= MaxCycles) begin
      $display("timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Done: errors found");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // memory side, acks a held request after 0 to 3 idle cycles
  always @(posedge clk_i) begin
    if (mem_ack_i) begin
      mem_ack_i <= 1'b0;
    end else if (rst_ni && mem_req_o) begin
      if (ack_wait == 0) begin
        mem_ack_i <= 1'b1;
        rng_q = xorshift32(rng_q);
        ack_wait <= int'(rng_q % 4);
      end else begin
        ack_wait <= ack_wait - 1;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_err(input string msg);
    errors++;
    $display("ERR %0t: %s", $time, msg);
  endtask

  task automatic end_test(input string name);
    tests_run++;
    if (errors != test_errors) begin
      tests_failed++;
    end
    $display("test %s: %s (%0d errors)", name, (errors == test_errors) ? "ok" : "FAILED",
             errors - test_errors);
    test_errors = errors;
  endtask

  // address with the bits below the access size cleared
  function automatic paddr_t expect_addr(paddr_t a, size_t s);
    paddr_t mask;
    mask = '1;
    if (s == 3'd1) mask = ~32'h1;
    if (s == 3'd2) mask = ~32'h3;
    if (s == 3'd3) mask = ~32'h7;
    if (s == 3'd7) mask = ~32'hf;
    return a & mask;
  endfunction

  // store data tied to the address so a wrong port shows up
  function automatic word_t store_data(paddr_t a);
    return {~a, a};
  endfunction

  function automatic int first_free(logic [3:0] vld);
    int w;
    w = -1;
    for (int i = 3; i >= 0; i--) begin
      if (!vld[i]) w = i;
    end
    return w;
  endfunction

  // wait for the port's ack, then check the request seen on memory
  task automatic wait_ack(input int port, input paddr_t addr, input size_t size, input tid_t id,
                          input logic [3:0] vld);
    int way;
    way = first_free(vld);
    @(negedge clk_i);
    while (!miss_ack_o[port]) @(negedge clk_i);
    assert (miss_ack_o == (3'b001 << port) && mem_req_o)
      else report_err($sformatf("ack %b on port %0d", miss_ack_o, port));
    assert (mem_paddr_o == expect_addr(addr, size) && mem_tid_o == id && mem_size_o == size)
      else report_err($sformatf("request addr %h id %0d", mem_paddr_o, mem_tid_o));
    if (port == NumPorts - 1) begin
      assert (mem_type_o == REQ_STORE && mem_way_o == 2'd0 && !miss_o)
        else report_err("store went out with the wrong type or way");
      assert (mem_wdata_o == store_data(addr))
        else report_err($sformatf("store data %h", mem_wdata_o));
    end else begin
      assert (mem_type_o == REQ_LOAD && miss_o)
        else report_err("read went out without load type or miss flag");
      if (way >= 0) begin
        assert (mem_way_o == 2'(way))
          else report_err($sformatf("way %0d, expected %0d", mem_way_o, way));
      end
    end
  endtask

  task automatic issue(input int port, input paddr_t addr, input size_t size, input tid_t id,
                       input logic [3:0] vld);
    @(posedge clk_i);
    miss_paddr_i[port]    <= addr;
    miss_size_i[port]     <= size;
    miss_id_i[port]       <= id;
    miss_vld_bits_i[port] <= vld;
    miss_wdata_i[port]    <= store_data(addr);
    miss_req_i[port]      <= 1'b1;
    wait_ack(port, addr, size, id, vld);
    @(posedge clk_i);
    miss_req_i[port] <= 1'b0;
  endtask

  // one return after a random delay, we_exp of all ones accepts any single way
  task automatic send_return(input rtrn_type_e t, input tid_t tid, input logic [2:0] vld_exp,
                             input paddr_t addr, input logic [3:0] we_exp);
    int d;
    rng_q = xorshift32(rng_q);
    d = int'(rng_q % 4);
    repeat (d) @(posedge clk_i);
    @(posedge clk_i);
    mem_rtrn_vld_i  <= 1'b1;
    mem_rtrn_type_i <= t;
    mem_rtrn_tid_i  <= tid;
    mem_rtrn_data_i <= {4{rng_q}};
    @(negedge clk_i);
    assert (miss_rtrn_vld_o == vld_exp)
      else report_err($sformatf("return valid %b, expected %b", miss_rtrn_vld_o, vld_exp));
    if (t == RTRN_LOAD_ACK && vld_exp != '0) begin
      assert (wr_cl_vld_o && miss_rtrn_id_o == tid && wr_cl_data_o == {4{rng_q}})
        else report_err("refill without line write or with wrong id or data");
      assert (wr_cl_tag_o == addr[31:8] && wr_cl_idx_o == addr[7:4])
        else report_err($sformatf("refill tag %h idx %0d", wr_cl_tag_o, wr_cl_idx_o));
      if (we_exp == '1) begin
        assert ($onehot(wr_cl_we_o)) else report_err("refill enables more than one way");
      end else begin
        assert (wr_cl_we_o == we_exp) else report_err($sformatf("refill we %b", wr_cl_we_o));
      end
      assert (wr_vld_bits_o == wr_cl_we_o) else report_err("refill valid bits differ from we");
    end
    @(posedge clk_i);
    mem_rtrn_vld_i <= 1'b0;
  endtask

  // one flush walk over all lines, counting flush acks
  task automatic check_walk(input int acks_exp);
    int acks;
    acks = 0;
    @(negedge clk_i);
    while (!wr_cl_vld_o) @(negedge clk_i);
    for (int i = 0; i < 16; i++) begin
      if (i > 0) begin
        @(posedge clk_i);
        if (i == 1) flush_i <= 1'b0;
        @(negedge clk_i);
      end
      assert (wr_cl_vld_o && wr_cl_we_o == '1 && wr_vld_bits_o == '0 && wr_cl_idx_o == 4'(i))
        else report_err($sformatf("walk step %0d wrote idx %0d", i, wr_cl_idx_o));
      if (flush_ack_o) begin
        acks++;
        assert (i == 15) else report_err("flush ack before the last line");
      end
    end
    assert (acks == acks_exp) else report_err($sformatf("%0d flush acks seen", acks));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // tests
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    errors          = 0;
    test_errors     = 0;
    tests_run       = 0;
    tests_failed    = 0;
    cycles          = 0;
    rng_q           = 32'd56;
    ack_wait        = 0;
    rst_ni          = 1'b0;
    enable_i        = 1'b0;
    flush_i         = 1'b0;
    wbuffer_empty_i = 1'b1;
    miss_req_i      = '0;
    miss_paddr_i    = '0;
    miss_size_i     = '0;
    miss_id_i       = '0;
    miss_vld_bits_i = '0;
    miss_wdata_i    = '0;
    mem_ack_i       = 1'b0;
    mem_rtrn_vld_i  = 1'b0;
    mem_rtrn_type_i = RTRN_OTHER;
    mem_rtrn_tid_i  = '0;
    mem_rtrn_data_i = '0;
    repeat (3) @(posedge clk_i);
    rst_ni <= 1'b1;

    // walk after reset, then a second one on enable
    check_walk(0);
    @(negedge clk_i);
    assert (!cache_en_o) else report_err("cache enabled before enable_i");
    @(posedge clk_i);
    enable_i <= 1'b1;
    check_walk(0);
    @(negedge clk_i);
    assert (cache_en_o) else report_err("cache not enabled after the enable walk");
    end_test("reset_flush");

    issue(1, 32'h0001_2345, 3'd2, 4'd5, 4'b0011);
    send_return(RTRN_LOAD_ACK, 4'd5, 3'b010, 32'h0001_2344, 4'b0100);
    issue(1, 32'h00ab_cd10, 3'd7, 4'd6, 4'b1111);
    send_return(RTRN_LOAD_ACK, 4'd6, 3'b010, 32'h00ab_cd10, 4'b1111);
    end_test("read_refill");

    @(posedge clk_i);
    miss_paddr_i[0]    <= 32'h0000_1000;
    miss_size_i[0]     <= 3'd3;
    miss_id_i[0]       <= 4'd1;
    miss_vld_bits_i[0] <= 4'b0000;
    miss_paddr_i[1]    <= 32'h0000_2000;
    miss_size_i[1]     <= 3'd3;
    miss_id_i[1]       <= 4'd2;
    miss_vld_bits_i[1] <= 4'b0001;
    miss_req_i[1:0]    <= 2'b11;
    wait_ack(0, 32'h0000_1000, 3'd3, 4'd1, 4'b0000);
    @(posedge clk_i);
    miss_req_i[0] <= 1'b0;
    send_return(RTRN_LOAD_ACK, 4'd1, 3'b001, 32'h0000_1000, 4'b0001);
    wait_ack(1, 32'h0000_2000, 3'd3, 4'd2, 4'b0001);
    @(posedge clk_i);
    miss_req_i[1] <= 1'b0;
    send_return(RTRN_LOAD_ACK, 4'd2, 3'b010, 32'h0000_2000, 4'b0010);
    end_test("priority");

    issue(2, 32'h0000_3003, 3'd1, 4'd7, 4'b0000);
    send_return(RTRN_STORE_ACK, 4'd7, 3'b100, '0, '0);
    // nothing outstanding, so this ack is dropped
    send_return(RTRN_STORE_ACK, 4'd7, 3'b000, '0, '0);
    end_test("stores");

    issue(0, 32'h0000_4000, 3'd3, 4'd3, 4'b0000);
    @(posedge clk_i);
    miss_paddr_i[2] <= 32'h0000_4008;
    miss_size_i[2]  <= 3'd3;
    miss_id_i[2]    <= 4'd8;
    miss_wdata_i[2] <= store_data(32'h0000_4008);
    miss_req_i[2]   <= 1'b1;
    repeat (6) begin
      @(negedge clk_i);
      assert (!mem_req_o && miss_ack_o == '0)
        else report_err("store to the pending line was requested");
    end
    send_return(RTRN_LOAD_ACK, 4'd3, 3'b001, 32'h0000_4000, 4'b0001);
    wait_ack(2, 32'h0000_4008, 3'd3, 4'd8, 4'b0000);
    @(posedge clk_i);
    miss_req_i[2] <= 1'b0;
    send_return(RTRN_STORE_ACK, 4'd8, 3'b100, '0, '0);
    end_test("write_stall");

    @(posedge clk_i);
    wbuffer_empty_i <= 1'b0;
    flush_i <= 1'b1;
    repeat (8) begin
      @(negedge clk_i);
      assert (!wr_cl_vld_o && !flush_ack_o) else report_err("walk began before the drain");
    end
    @(posedge clk_i);
    wbuffer_empty_i <= 1'b1;
    check_walk(1);
    repeat (4) begin
      @(negedge clk_i);
      assert (!wr_cl_vld_o && !flush_ack_o) else report_err("extra walk or ack after flush");
    end
    end_test("flush_request");

    $display("tests run %0d, tests failed %0d, errors %0d", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== src.f ====
common/miss_pkg.sv
miss_unit/miss_arbiter.sv
miss_unit/miss_mshr.sv
miss_unit/miss_ctrl.sv
miss_unit/miss_unit.sv
tests/tb_miss_unit.sv

// ==== run.sh ====
#!/usr/bin/env bash
# build and run the miss unit testbench with Verilator

cd "$(dirname "$0")" || exit 1

BUILD_DIR=build
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f src.f --top-module tb_miss_unit \
  -Mdir "$BUILD_DIR" -o sim_tb_miss_unit
if [ $? -ne 0 ]; then
  echo "build failed"
  exit 1
fi

"./$BUILD_DIR/sim_tb_miss_unit" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "Done: no errors" "$LOG"; then
  exit 0
else
  echo "simulation reported failure"
  exit 1
fi
